// ==== ddr_ctrl.f ====
logic/ddr_pkg.sv
logic/app_timing_ctrl.sv
logic/app_mem_array.sv
logic/ram_port_ctrl.sv
logic/ddr_ctrl.sv
dv/ddr_ctrl_properties.sv
dv/ddr_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the ddr_ctrl testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module ddr_ctrl_tb \
    -f ddr_ctrl.f -Mdir obj_dir -o ddr_ctrl_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ddr_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0

// ==== dv/ddr_ctrl_tb.sv ====
// directed tests for the cpu memory port against a reference memory
// run as top module ddr_ctrl_tb
`default_nettype none

module ddr_ctrl_tb
    import ddr_pkg::*;
;

    localparam int MEM_WORDS      = 256;
    localparam int READ_LATENCY   = 4;
    localparam int CALIB_CYCLES   = 20;
    localparam int REFRESH_PERIOD = 64;
    localparam int REFRESH_LEN    = 6;
    localparam int NUM_REQUESTS   = 64;   // every request counts as one test step
    localparam int TIMEOUT = NUM_REQUESTS
                             * (CALIB_CYCLES + REFRESH_PERIOD + READ_LATENCY + 20) * 40;

    logic                  ui_clk;
    logic                  rst;
    logic                  ram_en;
    logic                  ram_write;
    logic [CPU_ADDR_W-1:0] ram_addr;
    logic [BLOCK_W-1:0]    data_to_ram;
    logic                  ram_rdy;
    logic [APP_DATA_W-1:0] block_out;

    logic [APP_DATA_W-1:0] ref_mem [MEM_WORDS];
    logic                  written [MEM_WORDS];
    logic [CPU_ADDR_W-1:0] last_addr;
    cpu_op_t               last_op;
    int                    seed = 32'h0e36_d82d;
    int                    errors;
    int                    tests_ok;
    int                    tests_bad;

    ddr_ctrl #(
        .MEM_WORDS      (MEM_WORDS),
        .READ_LATENCY   (READ_LATENCY),
        .CALIB_CYCLES   (CALIB_CYCLES),
        .REFRESH_PERIOD (REFRESH_PERIOD),
        .REFRESH_LEN    (REFRESH_LEN)
    ) dut_i (
        .ui_clk      (ui_clk),
        .rst         (rst),
        .ram_en      (ram_en),
        .ram_write   (ram_write),
        .ram_addr    (ram_addr),
        .data_to_ram (data_to_ram),
        .ram_rdy     (ram_rdy),
        .block_out   (block_out)
    );

    always #20 ui_clk = ~ui_clk;

    initial begin
        #(TIMEOUT);
        $display("timeout: the port stopped answering requests");
        $display("sim failed");
        $finish;
    end

    // --------------------
    // compare tasks

    task automatic check_block(input logic [APP_DATA_W-1:0] exp,
                               input logic [APP_DATA_W-1:0] got, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, expected %h got %h", $time, msg, exp, got);
            errors++;
        end
    endtask

    task automatic check_op(input cpu_op_t exp, input cpu_op_t got, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, expected %s got %s",
                     $time, msg, exp.name(), got.name());
            errors++;
        end
    endtask

    task automatic check_flag(input logic exp, input logic got, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, expected %b got %b", $time, msg, exp, got);
            errors++;
        end
    endtask

    // --------------------
    // request helpers

    // app address {addr[24:0], 2'b00}, eight per 128-bit word, wraps on depth
    function automatic int ref_index(input logic [CPU_ADDR_W-1:0] addr);
        logic [APP_ADDR_W-1:0] app_a;
        app_a = {addr[APP_ADDR_W-3:0], 2'b00};
        return int'(app_a >> 3) % MEM_WORDS;
    endfunction

    function automatic logic [BLOCK_W-1:0] rand_block();
        logic [BLOCK_W-1:0] b;
        for (int i = 0; i < BLOCK_W / 32; i++) begin
            b[i*32 +: 32] = $random(seed);
        end
        return b;
    endfunction

    task automatic start_request(input logic wr, input logic [CPU_ADDR_W-1:0] addr,
                                 input logic [BLOCK_W-1:0] data);
        @(posedge ui_clk);
        #2;
        ram_en      = 1'b1;
        ram_write   = wr;
        ram_addr    = addr;
        data_to_ram = data;
    endtask

    task automatic finish_request(input logic wr, input logic [CPU_ADDR_W-1:0] addr,
                                  input logic [BLOCK_W-1:0] data);
        cpu_op_t op;
        logic    is_new;
        int      idx;
        op     = wr ? OP_WRITE : OP_READ;
        is_new = (addr != last_addr) || (op != last_op);
        idx    = ref_index(addr);
        @(negedge ui_clk);
        check_flag(!is_new, ram_rdy, "ram_rdy in the first cycle of a request");
        while (!ram_rdy) @(negedge ui_clk);
        if (wr && is_new) begin
            ref_mem[idx] = addr[4] ? data[BLOCK_W-1:APP_DATA_W] : data[APP_DATA_W-1:0];
            written[idx] = 1'b1;
        end
        if (!wr) check_block(ref_mem[idx], block_out, "read data");
        check_op(op, dut_i.port_i.last_op, "last completed operation");
        last_addr = addr;
        last_op   = op;
    endtask

    task automatic do_request(input logic wr, input logic [CPU_ADDR_W-1:0] addr,
                              input logic [BLOCK_W-1:0] data);
        start_request(wr, addr, data);
        finish_request(wr, addr, data);
    endtask

    // returns at the falling edge in the first cycle of a refresh window
    task automatic wait_refresh_window();
        @(negedge ui_clk);
        while (dut_i.refresh_active) @(negedge ui_clk);
        while (!dut_i.refresh_active) @(negedge ui_clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
            tests_bad++;
        end
    endtask

    // --------------------
    // directed tests

    task automatic test_calib_holdoff();
        int                 e0;
        logic [BLOCK_W-1:0] d;
        e0 = errors;
        d  = rand_block();
        check_op(OP_NOP, dut_i.port_i.last_op, "operation after reset");
        start_request(1'b1, 30'h4, d);
        while (!dut_i.init_calib_complete) begin
            @(negedge ui_clk);
            check_flag(1'b0, ram_rdy, "ram_rdy during calibration");
        end
        finish_request(1'b1, 30'h4, d);
        do_request(1'b0, 30'h4, '0);
        check_block(d[APP_DATA_W-1:0], block_out, "read-back after calibration");
        report_test("calib_holdoff", e0);
    endtask

    task automatic test_half_select();
        int                 e0;
        logic [BLOCK_W-1:0] d;
        e0 = errors;
        d  = rand_block();
        do_request(1'b1, 30'h10, d);   // bit 4 set, upper half
        do_request(1'b1, 30'h20, d);
        do_request(1'b0, 30'h10, '0);
        check_block(d[BLOCK_W-1:APP_DATA_W], block_out, "upper half");
        do_request(1'b0, 30'h20, '0);
        check_block(d[APP_DATA_W-1:0], block_out, "lower half");
        report_test("half_select", e0);
    endtask

    task automatic test_repeat_filter();
        int                    e0;
        logic [APP_DATA_W-1:0] held;
        e0 = errors;
        do_request(1'b1, 30'h30, rand_block());
        do_request(1'b0, 30'h30, '0);
        held = ref_mem[ref_index(30'h30)];
        repeat (8) begin
            @(negedge ui_clk);
            check_flag(1'b1, ram_rdy, "ram_rdy on a held repeat");
            check_block(held, block_out, "block_out on a held repeat");
        end
        report_test("repeat_filter", e0);
    endtask

    task automatic test_refresh();
        int                    e0;
        logic [CPU_ADDR_W-1:0] a;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            a = CPU_ADDR_W'(32'h100 + i * 18);
            wait_refresh_window();   // command meets app_rdy low
            do_request(1'b1, a, rand_block());
            wait_refresh_window();
            do_request(1'b0, a, '0);
        end
        report_test("refresh", e0);
    endtask

    task automatic test_random();
        int                    e0;
        int                    rnd;
        logic                  wr;
        logic [CPU_ADDR_W-1:0] a;
        e0 = errors;
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            wr  = rnd[0];
            a   = CPU_ADDR_W'($random(seed)) & 30'h7f;
            if (!wr && !written[ref_index(a)]) wr = 1'b1;   // no reads of unwritten words
            do_request(wr, a, rand_block());
        end
        report_test("random", e0);
    endtask

    // --------------------
    // main sequence

    initial begin
        ui_clk      = 1'b0;
        rst         = 1'b1;
        ram_en      = 1'b0;
        ram_write   = 1'b0;
        ram_addr    = '0;
        data_to_ram = '0;
        last_addr   = '0;
        last_op     = OP_NOP;
        errors      = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            written[i] = 1'b0;
        end
        repeat (3) @(posedge ui_clk);
        #2;
        rst = 1'b0;

        test_calib_holdoff();
        test_half_select();
        test_repeat_filter();
        test_refresh();
        test_random();

        $display("tests: %0d passed, %0d failed", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : ddr_ctrl_tb

`default_nettype wire

// ==== dv/ddr_ctrl_properties.sv ====
// level protocol checks on the port controller
// bound into every ram_port_ctrl instance
`default_nettype none

module ddr_ctrl_properties
    import ddr_pkg::*;
(
    input wire logic                  ui_clk,
    input wire logic                  rst,
    input wire logic                  app_en,
    input wire logic                  app_rdy,
    input wire logic                  app_wdf_rdy,
    input wire logic                  app_wdf_wren,
    input wire logic                  init_calib_complete,
    input wire logic                  ram_rdy,
    input wire logic [APP_ADDR_W-1:0] app_addr,
    input wire port_state_t           state
);

    logic cmd_xfer;

    // same transfer rule as the memory side
    assign cmd_xfer = app_en && app_rdy && init_calib_complete
                      && (!app_wdf_wren || app_wdf_rdy);

    wren_needs_en: assert property (@(posedge ui_clk) disable iff (rst)
        app_wdf_wren |-> app_en)
        else $error("app_wdf_wren high without app_en");

    // command held until it transfers
    cmd_held: assert property (@(posedge ui_clk) disable iff (rst)
        app_en && !cmd_xfer |=> app_en && $stable(app_addr))
        else $error("app_en or app_addr changed before the transfer");

    rdy_low_busy: assert property (@(posedge ui_clk) disable iff (rst)
        state != ST_IDLE |-> !ram_rdy)
        else $error("ram_rdy high while the port is busy");

endmodule : ddr_ctrl_properties

bind ram_port_ctrl ddr_ctrl_properties props_i (
    .ui_clk              (ui_clk),
    .rst                 (rst),
    .app_en              (app_en),
    .app_rdy             (app_rdy),
    .app_wdf_rdy         (app_wdf_rdy),
    .app_wdf_wren        (app_wdf_wren),
    .init_calib_complete (init_calib_complete),
    .ram_rdy             (ram_rdy),
    .app_addr            (app_addr),
    .state               (state)
);

`default_nettype wire

// ==== logic/ddr_ctrl.sv ====
// top level of the cpu memory port: port controller, memory model and timing block
// all parameters are set here and handed down
`default_nettype none

module ddr_ctrl
    import ddr_pkg::*;
#(
    parameter int MEM_WORDS      = 256,
    parameter int READ_LATENCY   = 4,
    parameter int CALIB_CYCLES   = 20,
    parameter int REFRESH_PERIOD = 64,
    parameter int REFRESH_LEN    = 6
) (
    input  wire logic                  ui_clk,
    input  wire logic                  rst,
    input  wire logic                  ram_en,
    input  wire logic                  ram_write,
    input  wire logic [CPU_ADDR_W-1:0] ram_addr,
    input  wire logic [BLOCK_W-1:0]    data_to_ram,
    output logic                       ram_rdy,
    output logic      [APP_DATA_W-1:0] block_out
);

    // application interface
    logic                  app_en;
    app_cmd_t              app_cmd;
    logic [APP_ADDR_W-1:0] app_addr;
    logic [APP_DATA_W-1:0] app_wdf_data;
    logic                  app_wdf_wren;
    logic                  app_rdy;
    logic                  app_wdf_rdy;
    logic [APP_DATA_W-1:0] app_rd_data;
    logic                  app_rd_data_valid;

    logic init_calib_complete;
    logic refresh_active;   // memory only

    ram_port_ctrl port_i (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .ram_en              (ram_en),
        .ram_write           (ram_write),
        .ram_addr            (ram_addr),
        .data_to_ram         (data_to_ram),
        .init_calib_complete (init_calib_complete),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .app_rd_data         (app_rd_data),
        .app_rd_data_valid   (app_rd_data_valid),
        .ram_rdy             (ram_rdy),
        .block_out           (block_out),
        .app_en              (app_en),
        .app_cmd             (app_cmd),
        .app_addr            (app_addr),
        .app_wdf_data        (app_wdf_data),
        .app_wdf_wren        (app_wdf_wren)
    );

    app_mem_array #(
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) mem_i (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .init_calib_complete (init_calib_complete),
        .refresh_active      (refresh_active),
        .app_en              (app_en),
        .app_cmd             (app_cmd),
        .app_addr            (app_addr),
        .app_wdf_data        (app_wdf_data),
        .app_wdf_wren        (app_wdf_wren),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .app_rd_data         (app_rd_data),
        .app_rd_data_valid   (app_rd_data_valid)
    );

    app_timing_ctrl #(
        .CALIB_CYCLES   (CALIB_CYCLES),
        .REFRESH_PERIOD (REFRESH_PERIOD),
        .REFRESH_LEN    (REFRESH_LEN)
    ) timing_i (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .init_calib_complete (init_calib_complete),
        .refresh_active      (refresh_active)
    );

endmodule : ddr_ctrl

`default_nettype wire

// ==== logic/ram_port_ctrl.sv ====
// turns level-held cpu block requests into single 128-bit application commands
// repeats of the last completed request are answered from the local buffer
`default_nettype none

module ram_port_ctrl
    import ddr_pkg::*;
(
    input  wire logic                  ui_clk,
    input  wire logic                  rst,

    // cpu side, levels
    input  wire logic                  ram_en,
    input  wire logic                  ram_write,
    input  wire logic [CPU_ADDR_W-1:0] ram_addr,
    input  wire logic [BLOCK_W-1:0]    data_to_ram,
    output logic                       ram_rdy,
    output logic      [APP_DATA_W-1:0] block_out,

    // application interface
    input  wire logic                  init_calib_complete,
    input  wire logic                  app_rdy,
    input  wire logic                  app_wdf_rdy,
    input  wire logic [APP_DATA_W-1:0] app_rd_data,
    input  wire logic                  app_rd_data_valid,
    output logic                       app_en,
    output app_cmd_t                   app_cmd,
    output logic      [APP_ADDR_W-1:0] app_addr,
    output logic      [APP_DATA_W-1:0] app_wdf_data,
    output logic                       app_wdf_wren
);

    port_state_t           state;
    cpu_op_t               last_op;
    logic [CPU_ADDR_W-1:0] last_addr;
    logic                  rd_issued;   // read command accepted, waiting for data
    logic [BLOCK_W-1:0]    rd_buf;      // halves fill independently

    cpu_op_t cur_op;
    logic    new_req;
    logic    upper_half;
    logic    cmd_xfer;
    logic    wr_done;
    logic    rd_done;

    // --------------------
    // request decode

    assign cur_op     = ram_write ? OP_WRITE : OP_READ;
    assign upper_half = ram_addr[4];   // selects the 128-bit half of the block

    // differs from the last completed address/op pair
    assign new_req = ram_en && ((ram_addr != last_addr) || (cur_op != last_op));

    assign ram_rdy = !new_req && (state == ST_IDLE);

    // --------------------
    // application command

    assign app_en       = (state == ST_WRITE) || (state == ST_READ && !rd_issued);
    assign app_cmd      = (state == ST_WRITE) ? APP_CMD_WRITE : APP_CMD_READ;
    assign app_addr     = {ram_addr[APP_ADDR_W-3:0], 2'b00};   // top 5 cpu bits dropped
    assign app_wdf_data = upper_half ? data_to_ram[BLOCK_W-1:APP_DATA_W]
                                     : data_to_ram[APP_DATA_W-1:0];
    assign app_wdf_wren = (state == ST_WRITE);

    // write data must be taken alongside the command
    assign cmd_xfer = app_en && app_rdy && init_calib_complete
                      && (!app_wdf_wren || app_wdf_rdy);

    assign wr_done = (state == ST_WRITE) && cmd_xfer;
    assign rd_done = (state == ST_READ) && rd_issued && app_rd_data_valid;

    // --------------------
    // FSM and last request

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            last_op   <= OP_NOP;
            last_addr <= '1;
            rd_issued <= 1'b0;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    if (new_req) begin
                        state <= ram_write ? ST_WRITE : ST_READ;
                    end
                end
                ST_WRITE: begin
                    if (wr_done) begin
                        last_addr <= ram_addr;
                        last_op   <= OP_WRITE;
                        state     <= ST_IDLE;
                    end
                end
                ST_READ: begin
                    if (cmd_xfer) begin
                        rd_issued <= 1'b1;   // app_en drops from here
                    end
                    if (rd_done) begin
                        last_addr <= ram_addr;
                        last_op   <= OP_READ;
                        rd_issued <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // read buffer, one half per completed read
    always_ff @(posedge ui_clk) begin
        if (rd_done) begin
            if (upper_half) begin
                rd_buf[BLOCK_W-1:APP_DATA_W] <= app_rd_data;
            end else begin
                rd_buf[APP_DATA_W-1:0] <= app_rd_data;
            end
        end
    end

    assign block_out = upper_half ? rd_buf[BLOCK_W-1:APP_DATA_W]
                                  : rd_buf[APP_DATA_W-1:0];

endmodule : ram_port_ctrl

`default_nettype wire

// ==== logic/app_mem_array.sv ====
// behavioural memory behind a DDR style application interface
// 128-bit words, fixed read latency, ready strobes follow calibration and refresh
`default_nettype none

module app_mem_array
    import ddr_pkg::*;
#(
    parameter int MEM_WORDS    = 256,
    parameter int READ_LATENCY = 4    // at least 1
) (
    input  wire logic                  ui_clk,
    input  wire logic                  rst,
    input  wire logic                  init_calib_complete,
    input  wire logic                  refresh_active,

    input  wire logic                  app_en,
    input  wire app_cmd_t              app_cmd,
    input  wire logic [APP_ADDR_W-1:0] app_addr,
    input  wire logic [APP_DATA_W-1:0] app_wdf_data,
    input  wire logic                  app_wdf_wren,

    output logic                       app_rdy,
    output logic                       app_wdf_rdy,
    output logic      [APP_DATA_W-1:0] app_rd_data,
    output logic                       app_rd_data_valid
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [APP_DATA_W-1:0] mem [MEM_WORDS];

    // read delay line
    logic [READ_LATENCY-1:0] rd_valid_pipe;
    logic [APP_DATA_W-1:0]   rd_data_pipe [READ_LATENCY];

    logic [APP_ADDR_W-4:0] word_addr;
    logic [IDX_W-1:0]      mem_idx;
    logic                  cmd_xfer;
    logic                  wr_xfer;
    logic                  rd_xfer;

    // --------------------
    // ready and command decode

    // both strobes blocked until calibrated and during refresh
    assign app_rdy     = init_calib_complete && !refresh_active;
    assign app_wdf_rdy = init_calib_complete && !refresh_active;

    assign cmd_xfer = app_en && app_rdy;
    assign wr_xfer  = cmd_xfer && (app_cmd == APP_CMD_WRITE) && app_wdf_wren && app_wdf_rdy;
    assign rd_xfer  = cmd_xfer && (app_cmd == APP_CMD_READ);

    assign word_addr = app_addr[APP_ADDR_W-1:3];   // 8 app addresses per word
    assign mem_idx   = IDX_W'(word_addr % MEM_WORDS);

    // --------------------
    // array

    always_ff @(posedge ui_clk) begin
        if (wr_xfer) begin
            mem[mem_idx] <= app_wdf_data;
        end
    end

    // --------------------
    // read pipeline

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            rd_valid_pipe <= '0;
        end else begin
            for (int i = READ_LATENCY - 1; i > 0; i--) begin
                rd_valid_pipe[i] <= rd_valid_pipe[i-1];
            end
            rd_valid_pipe[0] <= rd_xfer;
        end
    end

    always_ff @(posedge ui_clk) begin
        for (int i = READ_LATENCY - 1; i > 0; i--) begin
            rd_data_pipe[i] <= rd_data_pipe[i-1];
        end
        if (rd_xfer) begin
            rd_data_pipe[0] <= mem[mem_idx];   // sampled on the accept edge
        end
    end

    assign app_rd_data       = rd_data_pipe[READ_LATENCY-1];
    assign app_rd_data_valid = rd_valid_pipe[READ_LATENCY-1];   // one cycle pulse

endmodule : app_mem_array

`default_nettype wire

// ==== logic/app_timing_ctrl.sv ====
// calibration hold-off and periodic refresh windows for the memory model
`default_nettype none

module app_timing_ctrl #(
    parameter int CALIB_CYCLES   = 20,   // at least 1
    parameter int REFRESH_PERIOD = 64,
    parameter int REFRESH_LEN    = 6
) (
    input  wire logic ui_clk,
    input  wire logic rst,
    output logic      init_calib_complete,
    output logic      refresh_active
);

    localparam int CAL_W = $clog2(CALIB_CYCLES + 1);
    localparam int REF_W = (REFRESH_PERIOD > 1) ? $clog2(REFRESH_PERIOD) : 1;

    logic [CAL_W-1:0] calib_cnt;
    logic [REF_W-1:0] refresh_cnt;

    // --------------------
    // calibration

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            calib_cnt           <= '0;
            init_calib_complete <= 1'b0;
        end else if (!init_calib_complete) begin
            if (calib_cnt == CAL_W'(CALIB_CYCLES - 1)) begin
                init_calib_complete <= 1'b1;
            end
            calib_cnt <= calib_cnt + 1'b1;
        end
    end

    // --------------------
    // refresh

    // free-running once calibrated
    always_ff @(posedge ui_clk) begin
        if (rst) begin
            refresh_cnt <= '0;
        end else if (init_calib_complete) begin
            if (refresh_cnt == REF_W'(REFRESH_PERIOD - 1)) begin
                refresh_cnt <= '0;
            end else begin
                refresh_cnt <= refresh_cnt + 1'b1;
            end
        end
    end

    // window at the start of each period
    assign refresh_active = init_calib_complete && (refresh_cnt < REF_W'(REFRESH_LEN));

endmodule : app_timing_ctrl

`default_nettype wire

// ==== logic/ddr_pkg.sv ====
// shared widths and enums for the cpu memory port and its memory model
// imported with a wildcard by every module that needs them
`default_nettype none

package ddr_pkg;

    // --------------------
    // widths
    localparam int CPU_ADDR_W = 30;   // 4 byte aligned word address
    localparam int BLOCK_W    = 256;  // cpu side block
    localparam int APP_DATA_W = 128;  // one application data word
    localparam int APP_ADDR_W = 27;

    // --------------------
    // encodings

    // last completed cpu operation, nop after reset
    typedef enum logic [1:0] {
        OP_READ  = 2'b00,
        OP_WRITE = 2'b01,
        OP_NOP   = 2'b11
    } cpu_op_t;

    // command carried on app_cmd
    typedef enum logic [2:0] {
        APP_CMD_WRITE = 3'b000,
        APP_CMD_READ  = 3'b001
    } app_cmd_t;

    // port controller FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ
    } port_state_t;

endpackage : ddr_pkg

`default_nettype wire
